// ==== renamePkg.sv ====
`default_nettype none

package renamePkg;

  // register file sizes
  localparam int numArch = 32;
  localparam int numPhys = 64;

  // registers not covered by the identity map start out free
  localparam int numFree = numPhys - numArch;

  localparam int robDepth = 16;

  // architectural register index
  typedef logic [$clog2(numArch)-1:0] archReg_t;

  // physical register index
  typedef logic [$clog2(numPhys)-1:0] physReg_t;

  // ROB slot index that wraps naturally
  typedef logic [$clog2(robDepth)-1:0] robIdx_t;

  // ROB occupancy or flush count from 0 to robDepth
  typedef logic [$clog2(robDepth):0] robCount_t;

  // free-list occupancy from 0 to numFree
  typedef logic [$clog2(numFree):0] freeCount_t;

  // recovery holds dispatch off until the ROB drains
  typedef enum logic {
    robRunning    = 1'b0,
    robRecovering = 1'b1
  } robState_t;

endpackage

`default_nettype wire

// ==== reorderBuffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module reorderBuffer (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 dispatchValid,
  input  renamePkg::archReg_t  dispatchArch,
  input  logic                 dispatchHalt,
  input  logic                 completeValid,
  input  renamePkg::robIdx_t   completeRobIdx,
  input  logic                 rollbackValid,
  input  renamePkg::robIdx_t   rollbackRobIdx,
  input  renamePkg::physReg_t  freeHead,
  input  logic                 freeEmpty,
  input  renamePkg::physReg_t  oldPhys,
  output logic                 dispatchReady,
  output renamePkg::robIdx_t   dispatchRobIdx,
  output renamePkg::physReg_t  dispatchPhys,
  output logic                 allocTake,
  output logic                 mapWrite,
  output renamePkg::archReg_t  mapArch,
  output renamePkg::physReg_t  mapPhys,
  output logic                 retireValid,
  output renamePkg::archReg_t  retireArch,
  output renamePkg::physReg_t  retirePhys,
  output renamePkg::physReg_t  retireOldPhys,
  output logic                 haltOut,
  output logic                 releaseValid,
  output renamePkg::physReg_t  releasePhys,
  output logic                 rewindValid,
  output renamePkg::robCount_t rewindCount,
  output logic                 commitValid,
  output renamePkg::archReg_t  commitArch,
  output renamePkg::physReg_t  commitPhys,
  output logic                 mapRestore
);

  renamePkg::robIdx_t   head;
  renamePkg::robIdx_t   tail;
  renamePkg::robCount_t count;
  renamePkg::robState_t state;

  // per-entry control bits
  logic entryValid    [renamePkg::robDepth];
  logic entryComplete [renamePkg::robDepth];

  // per-entry payload
  logic                entryHalt    [renamePkg::robDepth];
  renamePkg::archReg_t entryArch    [renamePkg::robDepth];
  renamePkg::physReg_t entryPhys    [renamePkg::robDepth];
  renamePkg::physReg_t entryOldPhys [renamePkg::robDepth];

  logic                         dispatchFire;
  logic                         rollbackAct;
  renamePkg::robIdx_t           branchAge;
  logic [renamePkg::robDepth-1:0] flushMask;

  // ready only looks at registered state
  assign dispatchReady = (count != renamePkg::robCount_t'(renamePkg::robDepth)) &&
                         !freeEmpty && (state == renamePkg::robRunning);
  assign dispatchRobIdx = tail;
  assign dispatchPhys   = freeHead;

  // rollback wins over a dispatch in the same cycle
  assign rollbackAct  = rollbackValid && entryValid[rollbackRobIdx] &&
                        (state == renamePkg::robRunning);
  assign dispatchFire = dispatchValid && dispatchReady && !rollbackAct;

  assign allocTake = dispatchFire;
  assign mapWrite  = dispatchFire;
  assign mapArch   = dispatchArch;
  assign mapPhys   = freeHead;

  // head retires as soon as it is complete
  assign retireValid   = entryValid[head] && entryComplete[head];
  assign retireArch    = entryArch[head];
  assign retirePhys    = entryPhys[head];
  assign retireOldPhys = entryOldPhys[head];
  assign haltOut       = retireValid && entryHalt[head];

  assign releaseValid = retireValid;
  assign releasePhys  = entryOldPhys[head];
  assign commitValid  = retireValid;
  assign commitArch   = entryArch[head];
  assign commitPhys   = entryPhys[head];

  // age of the branch relative to the head, so wrap needs no special case
  assign branchAge   = rollbackRobIdx - head;
  assign rewindValid = rollbackAct;
  assign rewindCount = count - renamePkg::robCount_t'(branchAge) - renamePkg::robCount_t'(1);

  // reload the speculative map once everything older has retired
  assign mapRestore = (state == renamePkg::robRecovering) && (count == '0);

  // slots younger than the branch but still occupied
  always_comb begin
    renamePkg::robIdx_t slotAge;
    flushMask = '0;
    for (int i = 0; i < renamePkg::robDepth; i++) begin
      slotAge = renamePkg::robIdx_t'(i) - head;
      flushMask[i] = (slotAge > branchAge) && (renamePkg::robCount_t'(slotAge) < count);
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
      state <= renamePkg::robRunning;
      for (int i = 0; i < renamePkg::robDepth; i++) begin
        entryValid[i]    <= 1'b0;
        entryComplete[i] <= 1'b0;
      end
    end else begin
      if (completeValid && entryValid[completeRobIdx]) begin
        entryComplete[completeRobIdx] <= 1'b1;
      end
      if (retireValid) begin
        entryValid[head] <= 1'b0;
      end
      if (dispatchFire) begin
        entryValid[tail]    <= 1'b1;
        entryComplete[tail] <= 1'b0;
      end
      if (rollbackAct) begin
        for (int i = 0; i < renamePkg::robDepth; i++) begin
          if (flushMask[i]) begin
            entryValid[i] <= 1'b0;
          end
        end
      end

      head <= head + renamePkg::robIdx_t'(retireValid);
      if (rollbackAct) begin
        tail  <= rollbackRobIdx + renamePkg::robIdx_t'(1);
        count <= renamePkg::robCount_t'(branchAge) + renamePkg::robCount_t'(1) -
                 renamePkg::robCount_t'(retireValid);
      end else begin
        tail  <= tail + renamePkg::robIdx_t'(dispatchFire);
        count <= count + renamePkg::robCount_t'(dispatchFire) -
                 renamePkg::robCount_t'(retireValid);
      end

      case (state)
        renamePkg::robRunning: begin
          if (rollbackAct) begin
            state <= renamePkg::robRecovering;
          end
        end
        renamePkg::robRecovering: begin
          if (count == '0) begin
            state <= renamePkg::robRunning;
          end
        end
      endcase
    end
  end

  // payload captured at the tail on dispatch
  always_ff @(posedge clock) begin
    if (dispatchFire) begin
      entryHalt[tail]    <= dispatchHalt;
      entryArch[tail]    <= dispatchArch;
      entryPhys[tail]    <= freeHead;
      entryOldPhys[tail] <= oldPhys;
    end
  end

endmodule

`default_nettype wire

// ==== freeList.sv ====
`timescale 1ns/1ps
`default_nettype none

module freeList (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 allocTake,
  input  logic                 releaseValid,
  input  renamePkg::physReg_t  releasePhys,
  input  logic                 rewindValid,
  input  renamePkg::robCount_t rewindCount,
  output renamePkg::physReg_t  freeHead,
  output logic                 freeEmpty
);

  renamePkg::physReg_t slots [renamePkg::numFree];

  logic [$clog2(renamePkg::numFree)-1:0] head;
  logic [$clog2(renamePkg::numFree)-1:0] headNext;
  logic [$clog2(renamePkg::numFree)-1:0] tail;

  renamePkg::freeCount_t count;
  renamePkg::freeCount_t countNext;

  // pops never overwrite a slot, so the head can step back over them
  assign freeHead  = slots[head];
  assign freeEmpty = (count == '0);

  always_comb begin
    headNext = head;
    if (allocTake) begin
      headNext = headNext + 1'b1;
    end
    if (rewindValid) begin
      // flushed registers come back in the order they left
      headNext = headNext - rewindCount;
    end
  end

  always_comb begin
    countNext = count + renamePkg::freeCount_t'(releaseValid) -
                renamePkg::freeCount_t'(allocTake);
    if (rewindValid) begin
      countNext = countNext + renamePkg::freeCount_t'(rewindCount);
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      head  <= '0;
      tail  <= '0;
      count <= renamePkg::freeCount_t'(renamePkg::numFree);
      // registers above the identity map in ascending order
      for (int i = 0; i < renamePkg::numFree; i++) begin
        slots[i] <= renamePkg::physReg_t'(renamePkg::numArch + i);
      end
    end else begin
      head  <= headNext;
      count <= countNext;
      if (releaseValid) begin
        slots[tail] <= releasePhys;
        tail        <= tail + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== mapTable.sv ====
`timescale 1ns/1ps
`default_nettype none

module mapTable (
  input  logic                                        clock,
  input  logic                                        reset,
  input  logic                                        mapWrite,
  input  renamePkg::archReg_t                         mapArch,
  input  renamePkg::physReg_t                         mapPhys,
  input  logic                                        mapRestore,
  input  renamePkg::physReg_t [renamePkg::numArch-1:0] archTable,
  output renamePkg::physReg_t                         oldPhys
);

  // speculative mapping, one entry per architectural register
  renamePkg::physReg_t [renamePkg::numArch-1:0] specMap;

  // previous mapping goes into the ROB entry being dispatched
  assign oldPhys = specMap[mapArch];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < renamePkg::numArch; i++) begin
        specMap[i] <= renamePkg::physReg_t'(i);
      end
    end else if (mapRestore) begin
      // recovery puts the whole table back to the committed state
      specMap <= archTable;
    end else if (mapWrite) begin
      specMap[mapArch] <= mapPhys;
    end
  end

endmodule

`default_nettype wire

// ==== archMap.sv ====
`timescale 1ns/1ps
`default_nettype none

module archMap (
  input  logic                                        clock,
  input  logic                                        reset,
  input  logic                                        commitValid,
  input  renamePkg::archReg_t                         commitArch,
  input  renamePkg::physReg_t                         commitPhys,
  output renamePkg::physReg_t [renamePkg::numArch-1:0] archTable
);

  // committed mapping that only retire moves
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < renamePkg::numArch; i++) begin
        archTable[i] <= renamePkg::physReg_t'(i);
      end
    end else if (commitValid) begin
      archTable[commitArch] <= commitPhys;
    end
  end

endmodule

`default_nettype wire

// ==== renameCore.sv ====
`timescale 1ns/1ps
`default_nettype none

module renameCore (
  input  logic                clock,
  input  logic                reset,
  input  logic                dispatchValid,
  input  renamePkg::archReg_t dispatchArch,
  input  logic                dispatchHalt,
  output logic                dispatchReady,
  output renamePkg::robIdx_t  dispatchRobIdx,
  output renamePkg::physReg_t dispatchPhys,
  input  logic                completeValid,
  input  renamePkg::robIdx_t  completeRobIdx,
  input  logic                rollbackValid,
  input  renamePkg::robIdx_t  rollbackRobIdx,
  output logic                retireValid,
  output renamePkg::archReg_t retireArch,
  output renamePkg::physReg_t retirePhys,
  output renamePkg::physReg_t retireOldPhys,
  output logic                haltOut
);

  // ROB to free list
  logic                 allocTake;
  renamePkg::physReg_t  freeHead;
  logic                 freeEmpty;
  logic                 releaseValid;
  renamePkg::physReg_t  releasePhys;
  logic                 rewindValid;
  renamePkg::robCount_t rewindCount;

  // ROB to the two maps
  logic                 mapWrite;
  renamePkg::archReg_t  mapArch;
  renamePkg::physReg_t  mapPhys;
  renamePkg::physReg_t  oldPhys;
  logic                 mapRestore;
  logic                 commitValid;
  renamePkg::archReg_t  commitArch;
  renamePkg::physReg_t  commitPhys;

  renamePkg::physReg_t [renamePkg::numArch-1:0] archTable;

  reorderBuffer robInst (
    .clock          (clock),
    .reset          (reset),
    .dispatchValid  (dispatchValid),
    .dispatchArch   (dispatchArch),
    .dispatchHalt   (dispatchHalt),
    .completeValid  (completeValid),
    .completeRobIdx (completeRobIdx),
    .rollbackValid  (rollbackValid),
    .rollbackRobIdx (rollbackRobIdx),
    .freeHead       (freeHead),
    .freeEmpty      (freeEmpty),
    .oldPhys        (oldPhys),
    .dispatchReady  (dispatchReady),
    .dispatchRobIdx (dispatchRobIdx),
    .dispatchPhys   (dispatchPhys),
    .allocTake      (allocTake),
    .mapWrite       (mapWrite),
    .mapArch        (mapArch),
    .mapPhys        (mapPhys),
    .retireValid    (retireValid),
    .retireArch     (retireArch),
    .retirePhys     (retirePhys),
    .retireOldPhys  (retireOldPhys),
    .haltOut        (haltOut),
    .releaseValid   (releaseValid),
    .releasePhys    (releasePhys),
    .rewindValid    (rewindValid),
    .rewindCount    (rewindCount),
    .commitValid    (commitValid),
    .commitArch     (commitArch),
    .commitPhys     (commitPhys),
    .mapRestore     (mapRestore)
  );

  freeList freeListInst (
    .clock        (clock),
    .reset        (reset),
    .allocTake    (allocTake),
    .releaseValid (releaseValid),
    .releasePhys  (releasePhys),
    .rewindValid  (rewindValid),
    .rewindCount  (rewindCount),
    .freeHead     (freeHead),
    .freeEmpty    (freeEmpty)
  );

  mapTable mapTableInst (
    .clock      (clock),
    .reset      (reset),
    .mapWrite   (mapWrite),
    .mapArch    (mapArch),
    .mapPhys    (mapPhys),
    .mapRestore (mapRestore),
    .archTable  (archTable),
    .oldPhys    (oldPhys)
  );

  archMap archMapInst (
    .clock       (clock),
    .reset       (reset),
    .commitValid (commitValid),
    .commitArch  (commitArch),
    .commitPhys  (commitPhys),
    .archTable   (archTable)
  );

endmodule

`default_nettype wire

// ==== renameCoreModel.svh ====
// reference state that the compare process keeps in step with the DUT

typedef struct packed {
  renamePkg::robIdx_t  idx;
  renamePkg::archReg_t arch;
  renamePkg::physReg_t phys;
  renamePkg::physReg_t oldPhys;
  logic                halt;
  logic                done;
} robEntry_t;

robEntry_t           robMirror[$];
renamePkg::physReg_t freeQueue[$];
renamePkg::physReg_t specMirror   [renamePkg::numArch];
renamePkg::physReg_t commitMirror [renamePkg::numArch];
renamePkg::robIdx_t  nextSlot;
logic                recovering;
logic [31:0]         lcgState;

function automatic logic [31:0] lcgNext();
  lcgState = lcgState * 32'd1664525 + 32'd1013904223;
  return lcgState;
endfunction

// low bits of an LCG are weak, so take the upper ones
function automatic int unsigned randBelow(input int unsigned limit);
  logic [31:0] r;
  r = lcgNext();
  return (r >> 8) % limit;
endfunction

function automatic void initReference();
  robMirror.delete();
  freeQueue.delete();
  for (int i = 0; i < renamePkg::numArch; i++) begin
    specMirror[i]   = renamePkg::physReg_t'(i);
    commitMirror[i] = renamePkg::physReg_t'(i);
    freeQueue.push_back(renamePkg::physReg_t'(renamePkg::numArch + i));
  end
  nextSlot   = '0;
  recovering = 1'b0;
endfunction

function automatic logic expectReady();
  return robMirror.size() < renamePkg::robDepth && freeQueue.size() > 0 && !recovering;
endfunction

function automatic logic expectRetire();
  return robMirror.size() > 0 && robMirror[0].done;
endfunction

// new mapping taken from the free queue, old one kept for retire
function automatic robEntry_t allocateEntry(input renamePkg::archReg_t arch, input logic halt);
  robEntry_t e;
  e.idx     = nextSlot;
  e.arch    = arch;
  e.phys    = freeQueue.pop_front();
  e.oldPhys = specMirror[arch];
  e.halt    = halt;
  e.done    = 1'b0;
  specMirror[arch] = e.phys;
  robMirror.push_back(e);
  nextSlot = nextSlot + renamePkg::robIdx_t'(1);
  return e;
endfunction

function automatic void markComplete(input renamePkg::robIdx_t idx);
  foreach (robMirror[i]) begin
    if (robMirror[i].idx == idx)
      robMirror[i].done = 1'b1;
  end
endfunction

// youngest first, so the free queue gets them back in allocation order
function automatic logic flushYounger(input renamePkg::robIdx_t idx);
  int k;
  robEntry_t e;
  k = -1;
  foreach (robMirror[i]) begin
    if (robMirror[i].idx == idx)
      k = i;
  end
  if (k < 0 || recovering)
    return 1'b0;
  while (robMirror.size() > k + 1) begin
    e = robMirror.pop_back();
    freeQueue.push_front(e.phys);
  end
  nextSlot   = idx + renamePkg::robIdx_t'(1);
  recovering = 1'b1;
  return 1'b1;
endfunction

function automatic void retireHead();
  robEntry_t e;
  e = robMirror.pop_front();
  commitMirror[e.arch] = e.phys;
  freeQueue.push_back(e.oldPhys);
endfunction

// drained ROB reloads the speculative map
function automatic void finishRecovery();
  if (recovering && robMirror.size() == 0) begin
    specMirror = commitMirror;
    recovering = 1'b0;
  end
endfunction

// ==== renameCoreTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module renameCoreTb;

  localparam int clockPeriod    = 40;
  localparam int resetCycles    = 3;
  localparam int watchdogCycles = 20000;
  localparam logic [31:0] lcgSeed = 32'h84db_6ea6;

  logic                clock;
  logic                reset;
  logic                dispatchValid;
  renamePkg::archReg_t dispatchArch;
  logic                dispatchHalt;
  logic                dispatchReady;
  renamePkg::robIdx_t  dispatchRobIdx;
  renamePkg::physReg_t dispatchPhys;
  logic                completeValid;
  renamePkg::robIdx_t  completeRobIdx;
  logic                rollbackValid;
  renamePkg::robIdx_t  rollbackRobIdx;
  logic                retireValid;
  renamePkg::archReg_t retireArch;
  renamePkg::physReg_t retirePhys;
  renamePkg::physReg_t retireOldPhys;
  logic                haltOut;

  int errorCount    = 0;
  int startErrors   = 0;
  int cycleCount    = 0;
  int retireCount   = 0;
  int dispatchCount = 0;

  `include "renameCoreModel.svh"

  renameCore renameCore_inst (
    .clock          (clock),
    .reset          (reset),
    .dispatchValid  (dispatchValid),
    .dispatchArch   (dispatchArch),
    .dispatchHalt   (dispatchHalt),
    .dispatchReady  (dispatchReady),
    .dispatchRobIdx (dispatchRobIdx),
    .dispatchPhys   (dispatchPhys),
    .completeValid  (completeValid),
    .completeRobIdx (completeRobIdx),
    .rollbackValid  (rollbackValid),
    .rollbackRobIdx (rollbackRobIdx),
    .retireValid    (retireValid),
    .retireArch     (retireArch),
    .retirePhys     (retirePhys),
    .retireOldPhys  (retireOldPhys),
    .haltOut        (haltOut)
  );

  always #(clockPeriod / 2) clock = ~clock;

  task automatic reportMismatch(input string what, input int got, input int expected);
    $display("FAIL @ %0t ns: %s is %0d, expected %0d", $time, what, got, expected);
    errorCount++;
  endtask

  // compare just before each rising edge, then advance the reference
  always @(negedge clock) begin
    robEntry_t entry;
    logic expReady;
    logic expRetire;
    logic rolledBack;
    if (!reset) begin
      expReady  = expectReady();
      expRetire = expectRetire();
      cycleCount++;
      if (dispatchReady !== expReady)
        reportMismatch("dispatchReady", dispatchReady, expReady);
      if (retireValid !== expRetire)
        reportMismatch("retireValid", retireValid, expRetire);
      if (expRetire) begin
        entry = robMirror[0];
        retireCount++;
        if (retireArch !== entry.arch)
          reportMismatch("retireArch", retireArch, entry.arch);
        if (retirePhys !== entry.phys)
          reportMismatch("retirePhys", retirePhys, entry.phys);
        if (retireOldPhys !== entry.oldPhys)
          reportMismatch("retireOldPhys", retireOldPhys, entry.oldPhys);
        if (retireOldPhys !== commitMirror[entry.arch])
          reportMismatch("retireOldPhys vs committed map", retireOldPhys,
                         commitMirror[entry.arch]);
        if (haltOut !== entry.halt)
          reportMismatch("haltOut", haltOut, entry.halt);
      end else if (haltOut !== 1'b0) begin
        reportMismatch("haltOut without retire", haltOut, 0);
      end
      finishRecovery();
      if (completeValid)
        markComplete(completeRobIdx);
      rolledBack = rollbackValid && flushYounger(rollbackRobIdx);
      if (expRetire)
        retireHead();
      if (dispatchValid && expReady && !rolledBack) begin
        entry = allocateEntry(dispatchArch, dispatchHalt);
        dispatchCount++;
        if (dispatchRobIdx !== entry.idx)
          reportMismatch("dispatchRobIdx", dispatchRobIdx, entry.idx);
        if (dispatchPhys !== entry.phys)
          reportMismatch("dispatchPhys", dispatchPhys, entry.phys);
      end
    end
  end

  // ready only moves on the rising edge, so the falling edge sees the final value
  task automatic finishCycle(output logic fired);
    @(negedge clock);
    fired = dispatchValid && dispatchReady && !rollbackValid;
    @(posedge clock);
    #2;
    completeValid = 1'b0;
    rollbackValid = 1'b0;
  endtask

  task automatic pickCompletion(input int unsigned pct);
    int open[$];
    foreach (robMirror[i]) begin
      if (!robMirror[i].done)
        open.push_back(i);
    end
    if (open.size() > 0 && randBelow(100) < pct) begin
      completeValid  = 1'b1;
      completeRobIdx = robMirror[open[randBelow(open.size())]].idx;
    end
  endtask

  // payload stays put while valid waits on ready
  task automatic dispatchBurst(input int numOps, input int unsigned compPct,
                               input int unsigned haltPct);
    int sent;
    logic fired;
    sent = 0;
    while (sent < numOps) begin
      if (!dispatchValid) begin
        dispatchValid = 1'b1;
        dispatchArch  = renamePkg::archReg_t'(randBelow(renamePkg::numArch));
        dispatchHalt  = randBelow(100) < haltPct;
      end
      pickCompletion(compPct);
      finishCycle(fired);
      if (fired) begin
        dispatchValid = 1'b0;
        sent++;
      end
    end
  endtask

  task automatic drainAll();
    logic fired;
    while (robMirror.size() > 0 || recovering) begin
      pickCompletion(100);
      finishCycle(fired);
    end
  endtask

  task automatic rollbackRandom();
    logic fired;
    if (robMirror.size() > 0) begin
      rollbackValid  = 1'b1;
      rollbackRobIdx = robMirror[randBelow(robMirror.size())].idx;
      finishCycle(fired);
    end
  endtask

  task automatic reportTest(input int num, input string name);
    if (errorCount == startErrors)
      $display("test %0d %s: ok", num, name);
    else
      $display("test %0d %s: %0d errors", num, name, errorCount - startErrors);
    startErrors = errorCount;
  endtask

  initial begin
    clock          = 1'b0;
    reset          = 1'b1;
    dispatchValid  = 1'b0;
    dispatchArch   = '0;
    dispatchHalt   = 1'b0;
    completeValid  = 1'b0;
    completeRobIdx = '0;
    rollbackValid  = 1'b0;
    rollbackRobIdx = '0;
    lcgState       = lcgSeed;
    initReference();
    repeat (resetCycles) @(posedge clock);
    #2;
    reset = 1'b0;

    dispatchBurst(8, 0, 0);
    drainAll();
    reportTest(1, "reset order and identity map");

    dispatchBurst(40, 50, 0);
    drainAll();
    reportTest(2, "out-of-order completion");

    // ROB fills long before the free list can run dry
    dispatchBurst(16, 0, 0);
    if (dispatchReady !== 1'b0)
      reportMismatch("dispatchReady with full ROB", dispatchReady, 0);
    dispatchBurst(6, 25, 0);
    drainAll();
    reportTest(3, "full ROB back-pressure");

    dispatchBurst(48, 60, 0);
    drainAll();
    reportTest(4, "free list wrap");

    repeat (4) begin
      dispatchBurst(8, 0, 0);
      dispatchBurst(4, 40, 0);
      rollbackRandom();
      dispatchBurst(6, 40, 0);
      drainAll();
    end
    reportTest(5, "rollback and recovery");

    dispatchBurst(30, 50, 30);
    drainAll();
    reportTest(6, "halt pulses");

    $display("%0d cycles, %0d dispatches, %0d retires compared, %0d errors",
             cycleCount, dispatchCount, retireCount, errorCount);
    if (errorCount == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // generous bound for the six tests
  initial begin
    #(watchdogCycles * clockPeriod);
    $display("timeout: run stopped after %0d cycles before the tests finished", watchdogCycles);
    $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

// ==== renameCore.f ====
+incdir+.
renamePkg.sv
reorderBuffer.sv
freeList.sv
mapTable.sv
archMap.sv
renameCore.sv
renameCoreTb.sv

// ==== runSim.sh ====
#!/bin/sh
# build and run the rename core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module renameCoreTb \
  -f renameCore.f -o renameCoreSim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/renameCoreSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "All tests passed!" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1
